// File: Makefile
# Verilator build and run of the object table DMA testbench

VERILATOR ?= verilator
TOP       ?= obj_dma_tb
FLIST     ?= obj_dma_top.f
BUILD     ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/obj_dma_tb.sv
/*
 * object table DMA testbench
 * - VRAM and bus arbiter model with random latency
 * - reference model of both buffer halves
 * - APB register, DMA, double buffer, back-pressure and restart tests
 */

`timescale 1ns/1ps

module obj_dma_tb
    import obj_pkg::*;
();

    logic        clk, rst;
    logic        psel, penable, pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic        frame_start, busreq, busack;
    logic [16:0] vram_addr;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic        scan_start;
    obj_entry_t  obj;
    logic        obj_valid, obj_ready, scan_done;

    // bus model and stimulus each step their own generator state
    logic [31:0] lfsr_main;
    logic [31:0] lfsr_bus;

    logic [15:0] vram_mem [0:131071];
    obj_entry_t  model_tab [0:1][0:obj_entries-1];
    int          model_cnt [0:1];
    logic        model_frame;
    int          last_half;
    int          frames;
    logic [6:0]  cur_base;
    bit          stall_en;

    tb_clock clk_gen (.clk(clk), .rst(rst));

    obj_dma_top dut0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .frame_start(frame_start), .busreq(busreq), .busack(busack),
        .vram_addr(vram_addr), .vram_data(vram_data), .vram_ok(vram_ok),
        .scan_start(scan_start), .obj(obj), .obj_valid(obj_valid),
        .obj_ready(obj_ready), .scan_done(scan_done)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] st, input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = st[31] ^ st[21] ^ st[1] ^ st[0];
            st = {st[30:0], fb};
            v  = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        string s;
        if (act !== exp) begin
            s = $sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run(s);
        end
    endtask

    task automatic check_entry(input string name, input obj_entry_t exp, input obj_entry_t act);
        string s;
        if (act !== exp) begin
            s = $sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run(s);
        end
    endtask

    task automatic check_status(input dma_status_t exp, input dma_status_t act);
        string s;
        if (act !== exp) begin
            s = $sformatf("[FAIL] %0t status expected %h actual %h", $time, exp, act);
            stop_run(s);
        end
    endtask

    // arbiter and VRAM, both react one step after the clock edge
    initial begin : bus_model
        logic [16:0] cur_addr;
        int          lat;
        bit          served;
        int          ack_wait;
        busack    = 1'b0;
        vram_ok   = 1'b0;
        vram_data = 16'h0000;
        cur_addr  = '0;
        lat       = 0;
        served    = 1'b1;
        ack_wait  = -1;
        forever begin
            @(posedge clk);
            #1;
            if (!busreq) begin
                busack   = 1'b0;
                ack_wait = -1;
            end else if (!busack) begin
                // grant after 0 to 7 cycles
                if (ack_wait < 0)
                    ack_wait = int'(lfsr_take(lfsr_bus, 3));
                else if (ack_wait == 0)
                    busack = 1'b1;
                else
                    ack_wait--;
            end
            if (busack && busreq) begin
                if (served || vram_addr != cur_addr) begin
                    // new read, answer after 1 to 4 cycles
                    cur_addr = vram_addr;
                    lat      = 1 + int'(lfsr_take(lfsr_bus, 2));
                    served   = 1'b0;
                    vram_ok  = 1'b0;
                end else if (lat > 1) begin
                    lat--;
                    vram_ok = 1'b0;
                end else begin
                    vram_ok   = 1'b1;
                    vram_data = vram_mem[cur_addr];
                    served    = 1'b1;
                end
            end else begin
                vram_ok = 1'b0;
                served  = 1'b1;
            end
        end
    end

    // random page content, some empty entries, one end marker at end_pos
    task automatic gen_table(input logic [6:0] page, input int end_pos);
        logic [16:0] a;
        logic [31:0] r;
        for (int e = 0; e < obj_entries; e++) begin
            for (int w = 0; w < 4; w++) begin
                a = {page, 8'(e), 2'(w)};
                r = lfsr_take(lfsr_main, 16);
                vram_mem[a] = (e % 9 == 5) ? 16'h0000 : r[15:0];
            end
            a = {page, 8'(e), 2'd3};
            if (vram_mem[a][15:8] == end_marker)
                vram_mem[a][15:8] = 8'h7f;
            if (e == end_pos)
                vram_mem[a][15:8] = end_marker;
        end
    endtask

    // copy rule: everything before the first marker, zeros after
    task automatic model_load(input logic [6:0] page, input int half);
        obj_entry_t ent;
        bit         ended;
        int         cnt;
        ended = 1'b0;
        cnt   = 0;
        for (int e = 0; e < obj_entries; e++) begin
            ent.attr = vram_mem[{page, 8'(e), 2'd3}];
            ent.code = vram_mem[{page, 8'(e), 2'd2}];
            ent.y    = vram_mem[{page, 8'(e), 2'd1}];
            ent.x    = vram_mem[{page, 8'(e), 2'd0}];
            if (ent.attr[15:8] == end_marker)
                ended = 1'b1;
            if (ended) begin
                model_tab[half][e] = '0;
            end else begin
                model_tab[half][e] = ent;
                cnt++;
            end
        end
        model_cnt[half] = cnt;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_word("pready", 32'd1, {31'd0, pready});
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // frame bit toggles, the fetcher fills the other half
    task automatic start_dma();
        model_frame = ~model_frame;
        last_half   = model_frame ? 0 : 1;
        frames++;
        model_load(cur_base, last_half);
        @(posedge clk);
        #1 frame_start = 1'b1;
        @(posedge clk);
        #1 frame_start = 1'b0;
    endtask

    task automatic wait_dma();
        int n;
        n = 0;
        @(negedge clk);
        while (busreq) begin
            n++;
            if (n > 20000)
                stop_run("timeout: DMA copy never released the bus");
            @(negedge clk);
        end
    endtask

    task automatic check_dma_status();
        logic [31:0] d;
        logic        err;
        dma_status_t exp;
        dma_status_t act;
        apb_read(reg_status, d, err);
        check_word("pslverr", 32'd0, {31'd0, err});
        exp = '{busy: 1'b0, frame: model_frame, count: 9'(model_cnt[last_half])};
        act = '{busy: d[0], frame: d[1], count: d[12:4]};
        check_status(exp, act);
        check_word("prdata frame count", 32'(frames), {16'd0, d[31:16]});
    endtask

    // one scan pass of the display half, checked entry by entry
    task automatic run_scan();
        obj_entry_t q[$];
        obj_entry_t prev;
        obj_entry_t exp;
        bit         prev_hold;
        bit         done;
        int         n;
        int         half;
        half = model_frame ? 1 : 0;
        for (int e = 0; e < obj_entries; e++)
            if (model_tab[half][e] != '0)
                q.push_back(model_tab[half][e]);
        @(posedge clk);
        #1 scan_start = 1'b1;
        @(posedge clk);
        #1 scan_start = 1'b0;
        prev_hold = 1'b0;
        prev      = '0;
        done      = 1'b0;
        n         = 0;
        while (!done) begin
            @(negedge clk);
            // a stalled entry must not move
            if (prev_hold) begin
                check_word("obj_valid", 32'd1, {31'd0, obj_valid});
                check_entry("obj", prev, obj);
            end
            if (obj_valid && obj_ready) begin
                if (q.size() == 0)
                    stop_run("scanner sent more entries than the table holds");
                exp = q.pop_front();
                check_entry("obj", exp, obj);
            end
            prev_hold = obj_valid && !obj_ready;
            prev      = obj;
            if (scan_done) begin
                done = 1'b1;
            end else begin
                n++;
                if (n > 20000)
                    stop_run("timeout: scan pass never signalled done");
                @(posedge clk);
                #1 obj_ready = stall_en ? (lfsr_take(lfsr_main, 2) != 0) : 1'b1;
            end
        end
        if (q.size() != 0)
            stop_run("scan finished with expected entries still missing");
        @(posedge clk);
        #1 obj_ready = 1'b1;
    endtask

    initial begin : main
        logic [31:0] d;
        logic        err;
        int          ep;
        int          n;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 4'h0;
        pwdata      = 32'd0;
        frame_start = 1'b0;
        scan_start  = 1'b0;
        obj_ready   = 1'b1;
        lfsr_main   = 32'hab68_2e1b;
        lfsr_bus    = 32'hab68_2e1b;
        model_frame = 1'b0;
        last_half   = 0;
        frames      = 0;
        cur_base    = 7'd3;
        stall_en    = 1'b0;
        model_cnt[0] = 0;
        model_cnt[1] = 0;
        n = 0;
        @(negedge clk);
        while (rst) begin
            n++;
            if (n > 100)
                stop_run("timeout: reset never released");
            @(negedge clk);
        end

        // registers after reset, read-back and an unmapped offset
        check_dma_status();
        apb_write(reg_base, 32'h0000_0003);
        apb_read(reg_base, d, err);
        check_word("prdata base", 32'h0000_0003, d);
        apb_write(reg_ctrl, 32'h0000_0001);
        apb_read(reg_ctrl, d, err);
        check_word("prdata ctrl", 32'h0000_0001, d);
        apb_read(4'hc, d, err);
        check_word("pslverr", 32'd1, {31'd0, err});
        check_word("prdata unmapped", 32'd0, d);

        // random end position
        ep = int'(lfsr_take(lfsr_main, 8));
        if (ep == 0)
            ep = 1;
        gen_table(cur_base, ep);
        start_dma();
        wait_dma();
        check_dma_status();
        // entries copied stop right at the marker
        apb_read(reg_status, d, err);
        check_word("status count", 32'(ep), {23'd0, d[12:4]});

        // no end marker, the previous table becomes visible
        gen_table(cur_base, obj_entries);
        start_dma();
        wait_dma();
        check_dma_status();
        run_scan();

        // scan during the next copy, with random stalls
        stall_en = 1'b1;
        gen_table(cur_base, 1 + int'(lfsr_take(lfsr_main, 7)));
        start_dma();
        run_scan();
        wait_dma();
        check_dma_status();

        // back-pressure on a full pass
        gen_table(cur_base, 1 + int'(lfsr_take(lfsr_main, 7)));
        start_dma();
        wait_dma();
        check_dma_status();
        run_scan();

        // restart mid-copy from another page
        gen_table(cur_base, obj_entries);
        start_dma();
        repeat (300) @(posedge clk);
        #1;
        check_word("busreq", 32'd1, {31'd0, busreq});
        apb_write(reg_base, 32'h0000_0005);
        cur_base = 7'd5;
        gen_table(cur_base, 1 + int'(lfsr_take(lfsr_main, 8)) % 255);
        start_dma();
        wait_dma();
        check_dma_status();
        // one more frame so the restarted copy is on display
        start_dma();
        wait_dma();
        check_dma_status();
        run_scan();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
/*
 * testbench clock and reset
 * 40 ns period, reset high for two cycles
 */

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: obj_dma_top.f
rtl/obj_pkg.sv
rtl/obj_regs.sv
rtl/obj_fetch.sv
rtl/obj_table_buf.sv
rtl/obj_scan.sv
rtl/obj_dma_top.sv
bench/tb_clock.sv
bench/obj_dma_tb.sv

// File: rtl/obj_dma_top.sv
/*
 * object table DMA subsystem top
 * APB registers, VRAM fetcher, double-buffered table and scanner
 */

`timescale 1ns/1ps

module obj_dma_top
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // APB register port
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // frame timing and video bus
    input  logic        frame_start,
    output logic        busreq,
    input  logic        busack,
    output logic [16:0] vram_addr,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    // renderer side
    input  logic        scan_start,
    output obj_entry_t  obj,
    output logic        obj_valid,
    input  logic        obj_ready,
    output logic        scan_done
);

    dma_cfg_t    cfg;
    dma_status_t status;
    tbl_wr_t     wr;
    logic        frame;
    logic [9:0]  rd_addr;
    logic [15:0] rd_data;

    obj_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .status  (status),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg)
    );

    obj_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .frame_start (frame_start),
        .busack      (busack),
        .vram_data   (vram_data),
        .vram_ok     (vram_ok),
        .busreq      (busreq),
        .vram_addr   (vram_addr),
        .wr          (wr),
        .frame       (frame),
        .status      (status)
    );

    obj_table_buf u_buf (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .frame   (frame),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .rd_data    (rd_data),
        .obj_ready  (obj_ready),
        .rd_addr    (rd_addr),
        .obj        (obj),
        .obj_valid  (obj_valid),
        .scan_done  (scan_done)
    );

endmodule

// File: rtl/obj_fetch.sv
/*
 * object table DMA fetcher
 * - takes the video bus at frame start
 * - copies VRAM words in 3,2,1,0 order per entry
 * - stops at the end marker and zero-fills the rest of the half
 * - owns the frame bit and the DMA status
 */

`timescale 1ns/1ps

module obj_fetch
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  dma_cfg_t    cfg,
    input  logic        frame_start,
    input  logic        busack,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output logic        busreq,
    output logic [16:0] vram_addr,
    output tbl_wr_t     wr,
    output logic        frame,
    output dma_status_t status
);

    fetch_state_t state;

    // word counter in natural order
    logic [9:0]  cnt;
    logic [8:0]  ent_cnt;
    // entries copied by the last finished DMA
    logic [8:0]  last_cnt;
    // page latched at start so a base write mid-copy has no effect
    logic [6:0]  page;
    // masks a vram_ok that still belongs to the previous address
    logic        wait_cycle;
    logic        start;
    logic        accept;
    logic        marker;
    logic        last_word;

    assign start     = frame_start && cfg.enable;
    assign accept    = (state == fetch_copy) && busack && vram_ok && !wait_cycle;
    // only the first word fetched of an entry is the attribute
    assign marker    = (cnt[1:0] == 2'b00) && (vram_data[15:8] == end_marker);
    assign last_word = (cnt == 10'(obj_words - 1));

    // bus held through copy and fill
    assign busreq    = (state != fetch_idle);

    // attribute word first, so the low bits run backwards
    assign vram_addr = {page, cnt[9:2], ~cnt[1:0]};

    assign status = '{busy: busreq, frame: frame, count: last_cnt};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= fetch_idle;
            frame      <= 1'b0;
            cnt        <= 10'd0;
            ent_cnt    <= 9'd0;
            last_cnt   <= 9'd0;
            page       <= 7'd0;
            wait_cycle <= 1'b0;
            wr         <= '0;
        end else begin
            wr.en <= 1'b0;
            if (start) begin
                // new frame, also aborts a copy or fill in progress
                frame      <= ~frame;
                page       <= cfg.base;
                cnt        <= 10'd0;
                ent_cnt    <= 9'd0;
                wait_cycle <= 1'b1;
                state      <= fetch_grant;
            end else begin
                case (state)
                    fetch_grant: begin
                        if (busack)
                            state <= fetch_copy;
                    end
                    fetch_copy: begin
                        wait_cycle <= 1'b0;
                        if (accept) begin
                            if (marker) begin
                                // cnt stays on the entry start for the fill
                                last_cnt <= ent_cnt;
                                state    <= fetch_fill;
                            end else begin
                                wr         <= '{en: 1'b1, addr: cnt, data: vram_data};
                                cnt        <= cnt + 10'd1;
                                wait_cycle <= 1'b1;
                                if (cnt[1:0] == 2'b11)
                                    ent_cnt <= ent_cnt + 9'd1;
                                // full table, nothing left to fill
                                if (last_word) begin
                                    last_cnt <= ent_cnt + 9'd1;
                                    state    <= fetch_idle;
                                end
                            end
                        end
                    end
                    fetch_fill: begin
                        // one zero word per cycle up to the end of the half
                        wr  <= '{en: 1'b1, addr: cnt, data: 16'h0000};
                        cnt <= cnt + 10'd1;
                        if (last_word)
                            state <= fetch_idle;
                    end
                    default: begin
                        state <= fetch_idle;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/obj_pkg.sv
/*
 * shared definitions for the object table DMA
 * - table sizes and end marker
 * - APB register offsets
 * - fetcher and scanner state enums
 * - table write, object entry, status and config structs
 */

package obj_pkg;

    // one buffer half, 256 entries of four words
    localparam int obj_words   = 1024;
    localparam int obj_entries = 256;

    // attribute high byte that closes the table
    localparam logic [7:0] end_marker = 8'hff;

    // APB byte offsets
    localparam logic [3:0] reg_ctrl   = 4'h0;
    localparam logic [3:0] reg_base   = 4'h4;
    localparam logic [3:0] reg_status = 4'h8;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_grant,
        fetch_copy,
        fetch_fill
    } fetch_state_t;

    typedef enum logic [1:0] {
        scan_idle,
        scan_read,
        scan_emit
    } scan_state_t;

    // addr counts in natural order, the buffer does the inversion
    typedef struct packed {
        logic        en;
        logic [9:0]  addr;
        logic [15:0] data;
    } tbl_wr_t;

    // attr is word 3 of the entry, x is word 0
    typedef struct packed {
        logic [15:0] attr;
        logic [15:0] code;
        logic [15:0] y;
        logic [15:0] x;
    } obj_entry_t;

    typedef struct packed {
        logic       busy;
        logic       frame;
        logic [8:0] count;
    } dma_status_t;

    typedef struct packed {
        logic       enable;
        logic [6:0] base;
    } dma_cfg_t;

endpackage

// File: rtl/obj_regs.sv
/*
 * APB register block of the object DMA
 * control (enable), VRAM page base, read-only status
 * status also carries a frame counter in its upper half
 */

`timescale 1ns/1ps

module obj_regs
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    input  dma_status_t status,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output dma_cfg_t    cfg
);

    logic        ctrl_en;
    logic [6:0]  base;
    logic [15:0] frame_cnt;
    logic        frame_q;
    logic        wr_acc;
    logic        mapped;

    // write lands on the access edge
    assign wr_acc = psel && penable && pwrite;
    assign mapped = (paddr == reg_ctrl) || (paddr == reg_base) || (paddr == reg_status);

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = psel && penable && !mapped;

    assign cfg = '{enable: ctrl_en, base: base};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ctrl_en   <= 1'b0;
            base      <= 7'd0;
            frame_cnt <= 16'd0;
            frame_q   <= 1'b0;
        end else begin
            // each toggle of the frame bit is one accepted frame
            frame_q <= status.frame;
            if (status.frame != frame_q)
                frame_cnt <= frame_cnt + 16'd1;
            if (wr_acc && paddr == reg_ctrl)
                ctrl_en <= pwdata[0];
            if (wr_acc && paddr == reg_base)
                base <= pwdata[6:0];
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        prdata = 32'd0;
        case (paddr)
            reg_ctrl:   prdata = {31'd0, ctrl_en};
            reg_base:   prdata = {25'd0, base};
            // frames 31:16, count 12:4, frame 1, busy 0
            reg_status: prdata = {frame_cnt, 3'd0, status.count, 2'd0, status.frame, status.busy};
            default:    prdata = 32'd0;
        endcase
    end

endmodule

// File: rtl/obj_scan.sv
/*
 * display-side table scanner
 * reads the display half entry by entry, skips empty entries
 * streams entries with valid/ready and holds them while stalled
 */

`timescale 1ns/1ps

module obj_scan
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        scan_start,
    input  logic [15:0] rd_data,
    input  logic        obj_ready,
    output logic [9:0]  rd_addr,
    output obj_entry_t  obj,
    output logic        obj_valid,
    output logic        scan_done
);

    scan_state_t state;

    logic [9:0]  addr;
    // read issued last cycle, data is on rd_data now
    logic        pend;
    logic        pend_last;
    // every word of the half has been issued
    logic        iss_end;
    obj_entry_t  acc;
    obj_entry_t  full;
    logic        done_word;
    logic        hold;
    logic        issue;
    logic        load_new;

    assign rd_addr = addr;

    // words arrive attr first, shift them in from the bottom
    assign full = '{attr: acc.code, code: acc.y, y: acc.x, x: rd_data};

    assign done_word = pend && pend_last;
    // entry ready but the output slot is still taken
    assign hold      = done_word && (full != '0) && obj_valid && !obj_ready;
    assign issue     = (state == scan_read) && !iss_end && !hold;
    assign load_new  = (state == scan_read) && done_word && (full != '0) && !hold;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= scan_idle;
            addr      <= 10'd0;
            pend      <= 1'b0;
            pend_last <= 1'b0;
            iss_end   <= 1'b0;
            obj_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            pend      <= issue;
            pend_last <= issue && (addr[1:0] == 2'b11);
            if (issue) begin
                addr <= addr + 10'd1;
                if (addr[9:2] == 8'(obj_entries - 1) && addr[1:0] == 2'b11)
                    iss_end <= 1'b1;
            end
            if (obj_valid && obj_ready)
                obj_valid <= 1'b0;
            case (state)
                scan_idle: begin
                    if (scan_start) begin
                        addr    <= 10'd0;
                        iss_end <= 1'b0;
                        state   <= scan_read;
                    end
                end
                scan_read: begin
                    if (hold)
                        state <= scan_emit;
                    else if (load_new)
                        obj_valid <= 1'b1;
                    else if (iss_end && !pend && (!obj_valid || obj_ready)) begin
                        // last entry gone, pass complete
                        scan_done <= 1'b1;
                        state     <= scan_idle;
                    end
                end
                scan_emit: begin
                    // slot frees, move the held entry out and resume reading
                    if (obj_ready) begin
                        obj_valid <= 1'b1;
                        state     <= scan_read;
                    end
                end
                default: begin
                    state <= scan_idle;
                end
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (pend)
            acc <= full;
        if (load_new)
            obj <= full;
        else if (state == scan_emit && obj_ready)
            obj <= acc;
    end

endmodule

// File: rtl/obj_table_buf.sv
/*
 * double-buffered object table RAM
 * fetcher writes half ~frame, scanner reads half frame
 * low two address bits inverted on both ports
 */

`timescale 1ns/1ps

module obj_table_buf
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  tbl_wr_t     wr,
    input  logic        frame,
    input  logic [9:0]  rd_addr,
    output logic [15:0] rd_data
);

    // both halves, frame bit selects the top address bit
    logic [15:0] mem [0:2*obj_words-1];

    logic [10:0] wr_idx;
    logic [10:0] rd_idx;

    // word 3 of each entry lands at offset 3 even though it comes first
    assign wr_idx = {~frame, wr.addr[9:2], ~wr.addr[1:0]};
    assign rd_idx = {frame, rd_addr[9:2], ~rd_addr[1:0]};

    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr_idx] <= wr.data;
    end

    // one cycle read latency
    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            rd_data <= 16'd0;
        else
            rd_data <= mem[rd_idx];
    end

endmodule
